// File: Makefile
# Verilator flow for the correlator testbench

VERILATOR ?= verilator
TOP       ?= tb_correlator
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --timing -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run passed"; \
	else \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/corr_pkg.sv
`include "corr_settings.svh"

package corr_pkg;

   // Index types
   typedef logic [$clog2(`CORR_ANTENNAS)-1:0] ant_idx_t;  // Antenna number
   typedef logic [$clog2(`CORR_PAIRS)-1:0]    pair_idx_t; // Global pair number

   // One strobed sample, real and quadrature bits
   typedef struct packed {
      logic [`CORR_ANTENNAS-1:0] re;     // Current antenna bits
      logic [`CORR_ANTENNAS-1:0] im;     // Bits of the previous strobed sample
      logic                      strobe; // Sample is valid
   } sample_t;

   // Visibility word, kind = 1
   typedef struct packed {
      logic                        kind;
      pair_idx_t                   pair;
      logic [`CORR_COUNT_BITS-1:0] re_count;
      logic [`CORR_COUNT_BITS-1:0] im_count;
   } vis_t;

   // Frame header word, kind = 0
   typedef struct packed {
      logic                        kind;
      logic [2:0]                  pad;     // Always zero
      logic [`CORR_COUNT_BITS-1:0] frame;   // Frame number
      logic [`CORR_COUNT_BITS-1:0] samples; // Samples per block
   } hdr_t;

   // Output word, the kind bit picks the view
   typedef union packed {
      vis_t vis;
      hdr_t hdr;
   } corr_word_u;

   // Pair table (0,1)(0,2)(0,3)(1,2)(1,3)(2,3)
   // Block b owns pairs 2b and 2b+1
   localparam ant_idx_t pair_ant_a [`CORR_PAIRS] = '{
      2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd2
   };
   localparam ant_idx_t pair_ant_b [`CORR_PAIRS] = '{
      2'd1, 2'd2, 2'd3, 2'd2, 2'd3, 2'd3
   };

endpackage

// File: design/corr_settings.svh
`ifndef CORR_SETTINGS_SVH
`define CORR_SETTINGS_SVH

// --------------------
// Array geometry
// --------------------
`define CORR_ANTENNAS        4   // One-bit antenna inputs
`define CORR_BLOCKS          3   // Correlator blocks
`define CORR_PAIRS_PER_BLOCK 2   // Pairs handled by each block
`define CORR_PAIRS           6   // All antenna pairs, blocks * pairs per block

// --------------------
// Counters and flow control
// --------------------
`define CORR_COUNT_BITS      16  // Accumulator width, also block size width
`define CORR_CREDITS         4   // Depth of the downstream buffer

`endif

// File: design/correlator_block.sv
`timescale 1ns/1ps
`include "corr_settings.svh"

module correlator_block (
   input  logic                        clk_i,
   input  logic                        sw_d,
   input  logic [1:0]                  block_id_i, // Fixed per instance
   input  corr_pkg::sample_t           sample_i,
   input  logic                        swap_i,
   input  logic                        rd_slot_i,  // Local pair of the read
   output logic [`CORR_COUNT_BITS-1:0] rd_re_o,
   output logic [`CORR_COUNT_BITS-1:0] rd_im_o
);

   localparam int CB  = `CORR_COUNT_BITS;
   localparam int PPB = `CORR_PAIRS_PER_BLOCK;

   corr_pkg::pair_idx_t pair_idx [PPB]; // Global pair per slot
   corr_pkg::ant_idx_t  ant_a    [PPB];
   corr_pkg::ant_idx_t  ant_b    [PPB];
   logic [CB-1:0]       inc_re   [PPB]; // Increment this cycle
   logic [CB-1:0]       inc_im   [PPB];

   // Accumulators indexed by bank then slot
   logic [CB-1:0] acc_re [2][PPB];
   logic [CB-1:0] acc_im [2][PPB];
   logic          bank_sel; // Active bank, the other one is frozen

   // --------------------
   // Pair lookup and compare
   // --------------------
   always_comb begin
      for (int s = 0; s < PPB; s++) begin
         pair_idx[s] = corr_pkg::pair_idx_t'(int'(block_id_i) * PPB + s);
         ant_a[s]    = corr_pkg::pair_ant_a[pair_idx[s]];
         ant_b[s]    = corr_pkg::pair_ant_b[pair_idx[s]];
         // Agreement counts, real against real and real against quadrature
         inc_re[s] = CB'(sample_i.strobe &&
                         (sample_i.re[ant_a[s]] == sample_i.re[ant_b[s]]));
         inc_im[s] = CB'(sample_i.strobe &&
                         (sample_i.re[ant_a[s]] == sample_i.im[ant_b[s]]));
      end
   end

   // --------------------
   // Double-banked accumulate
   // --------------------
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         bank_sel <= 1'b0;
         for (int k = 0; k < 2; k++) begin
            for (int s = 0; s < PPB; s++) begin
               acc_re[k][s] <= '0;
               acc_im[k][s] <= '0;
            end
         end
      end else begin
         if (swap_i) begin
            bank_sel <= ~bank_sel; // Old active bank becomes readable
         end
         for (int s = 0; s < PPB; s++) begin
            if (swap_i) begin
               // Fresh bank starts with the sample that came with swap
               acc_re[~bank_sel][s] <= inc_re[s];
               acc_im[~bank_sel][s] <= inc_im[s];
            end else begin
               acc_re[bank_sel][s] <= acc_re[bank_sel][s] + inc_re[s];
               acc_im[bank_sel][s] <= acc_im[bank_sel][s] + inc_im[s];
            end
         end
      end
   end

   // Read port into the frozen bank
   assign rd_re_o = acc_re[~bank_sel][rd_slot_i];
   assign rd_im_o = acc_im[~bank_sel][rd_slot_i];

endmodule

// File: design/correlator_top.sv
`timescale 1ns/1ps
`include "corr_settings.svh"

module correlator_top (
   input  logic                        clk_i,
   input  logic                        sw_d,
   input  logic                        enable_i,
   input  logic [`CORR_ANTENNAS-1:0]   antenna_i,
   input  logic [`CORR_COUNT_BITS-1:0] blocksize_i,
   input  logic                        credit_i,
   output corr_pkg::corr_word_u        word_o,
   output logic                        valid_o,
   output logic                        overrun_o
);

   corr_pkg::sample_t           sample;
   logic                        swap;
   logic [`CORR_COUNT_BITS-1:0] frame;
   corr_pkg::pair_idx_t         rd_pair;
   logic                        rd_slot;  // Local slot inside a block
   logic [`CORR_COUNT_BITS-1:0] rd_re [`CORR_BLOCKS];
   logic [`CORR_COUNT_BITS-1:0] rd_im [`CORR_BLOCKS];

   sample_front u_front (
      .clk_i       (clk_i),
      .sw_d        (sw_d),
      .enable_i    (enable_i),
      .antenna_i   (antenna_i),
      .blocksize_i (blocksize_i),
      .sample_o    (sample),
      .swap_o      (swap),
      .frame_o     (frame)
   );

   assign rd_slot = 1'(rd_pair % `CORR_PAIRS_PER_BLOCK);

   // --------------------
   // Correlator blocks, all share sample and read slot
   // --------------------
   for (genvar g = 0; g < `CORR_BLOCKS; g++) begin : g_blk
      correlator_block u_blk (
         .clk_i      (clk_i),
         .sw_d       (sw_d),
         .block_id_i (2'(g)),
         .sample_i   (sample),
         .swap_i     (swap),
         .rd_slot_i  (rd_slot),
         .rd_re_o    (rd_re[g]),
         .rd_im_o    (rd_im[g])
      );
   end

   visibility_drain u_drain (
      .clk_i       (clk_i),
      .sw_d        (sw_d),
      .swap_i      (swap),
      .frame_i     (frame),
      .blocksize_i (blocksize_i),
      .rd_pair_o   (rd_pair),
      .rd_re_i     (rd_re),
      .rd_im_i     (rd_im),
      .credit_i    (credit_i),
      .word_o      (word_o),
      .valid_o     (valid_o),
      .overrun_o   (overrun_o)
   );

endmodule

// File: design/sample_front.sv
`timescale 1ns/1ps
`include "corr_settings.svh"

module sample_front (
   input  logic                        clk_i,
   input  logic                        sw_d,
   input  logic                        enable_i,    // Acquisition enable
   input  logic [`CORR_ANTENNAS-1:0]   antenna_i,   // Real bit per antenna
   input  logic [`CORR_COUNT_BITS-1:0] blocksize_i, // Samples per block minus one
   output corr_pkg::sample_t           sample_o,
   output logic                        swap_o,      // Bank swap, one cycle
   output logic [`CORR_COUNT_BITS-1:0] frame_o      // Frame number
);

   logic [`CORR_ANTENNAS-1:0]   ant_q;  // Captured antennas
   logic                        en_q;   // Captured enable, the strobe
   logic [`CORR_ANTENNAS-1:0]   hist_q; // Last strobed bits
   logic [`CORR_COUNT_BITS-1:0] cnt_q;  // Strobed samples in this block
   logic                        pend_q; // Block full, swap on next strobe

   // --------------------
   // Capture
   // --------------------
   always_ff @(posedge clk_i) begin
      ant_q <= antenna_i; // Payload only
   end

   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         en_q   <= 1'b0;
         hist_q <= '0;
      end else begin
         en_q <= enable_i;
         if (en_q) begin
            hist_q <= ant_q; // One-sample-delay quadrature
         end
      end
   end

   // --------------------
   // Block counter
   // --------------------
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         cnt_q   <= '0;
         pend_q  <= 1'b0;
         frame_o <= '0;
      end else begin
         if (swap_o) begin
            pend_q  <= 1'b0;          // Swap taken
            frame_o <= frame_o + 1'b1;
         end
         if (en_q) begin
            if (cnt_q == blocksize_i) begin
               cnt_q  <= '0;
               pend_q <= 1'b1;        // Last sample of block, wins over clear
            end else begin
               cnt_q <= cnt_q + 1'b1;
            end
         end
      end
   end

   // Swap rides with the first sample of the next block
   assign swap_o = en_q && pend_q;

   assign sample_o.re     = ant_q;
   assign sample_o.im     = hist_q;
   assign sample_o.strobe = en_q;

endmodule

// File: design/visibility_drain.sv
`timescale 1ns/1ps
`include "corr_settings.svh"

module visibility_drain (
   input  logic                        clk_i,
   input  logic                        sw_d,
   input  logic                        swap_i,
   input  logic [`CORR_COUNT_BITS-1:0] frame_i,
   input  logic [`CORR_COUNT_BITS-1:0] blocksize_i,
   output corr_pkg::pair_idx_t         rd_pair_o,
   input  logic [`CORR_COUNT_BITS-1:0] rd_re_i [`CORR_BLOCKS],
   input  logic [`CORR_COUNT_BITS-1:0] rd_im_i [`CORR_BLOCKS],
   input  logic                        credit_i,  // One credit back per pulse
   output corr_pkg::corr_word_u        word_o,
   output logic                        valid_o,
   output logic                        overrun_o  // Sticky until reset
);

   localparam int          CW       = $clog2(`CORR_CREDITS + 1);
   localparam logic [2:0]  LAST_SEQ = 3'(`CORR_PAIRS); // Header plus six pairs

   logic                        busy;     // Frame in progress
   logic [2:0]                  seq;      // 0 is header, then pair + 1
   logic [CW-1:0]               credits;
   logic [`CORR_COUNT_BITS-1:0] frame_q;  // Latched at swap
   logic [`CORR_COUNT_BITS-1:0] blk_q;
   logic [1:0]                  blk_sel;  // Block owning the pair
   logic                        send;
   logic                        last;

   assign send = busy && (credits != '0); // Credit gate
   assign last = send && (seq == LAST_SEQ);

   // --------------------
   // Frame sequencer
   // --------------------
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         busy      <= 1'b0;
         seq       <= '0;
         overrun_o <= 1'b0;
      end else begin
         if (swap_i) begin
            busy <= 1'b1;
            seq  <= '0; // Restart on the new frame
            if (busy && !last) begin
               overrun_o <= 1'b1; // Old frame dropped
            end
         end else if (send) begin
            seq <= seq + 1'b1;
            if (last) begin
               busy <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (swap_i) begin
         frame_q <= frame_i;
         blk_q   <= blocksize_i;
      end
   end

   // --------------------
   // Credit counter
   // --------------------
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         credits <= CW'(`CORR_CREDITS);
      end else begin
         case ({send, credit_i})
            2'b10: credits <= credits - 1'b1;
            2'b01: begin
               if (credits < CW'(`CORR_CREDITS)) begin
                  credits <= credits + 1'b1; // Saturate at buffer depth
               end
            end
            default: credits <= credits; // Both or neither
         endcase
      end
   end

   // --------------------
   // Word build
   // --------------------
   assign rd_pair_o = (seq == '0) ? '0 : corr_pkg::pair_idx_t'(seq - 1'b1);
   assign blk_sel   = 2'(rd_pair_o / `CORR_PAIRS_PER_BLOCK);

   always_comb begin
      word_o = '0;
      if (seq == '0) begin
         word_o.hdr.kind    = 1'b0;
         word_o.hdr.pad     = '0;
         word_o.hdr.frame   = frame_q;
         word_o.hdr.samples = blk_q + 1'b1; // Block size as counted
      end else begin
         word_o.vis.kind     = 1'b1;
         word_o.vis.pair     = rd_pair_o;
         word_o.vis.re_count = rd_re_i[blk_sel];
         word_o.vis.im_count = rd_im_i[blk_sel];
      end
   end

   assign valid_o = send;

endmodule

// File: sources.f
+incdir+design
design/corr_pkg.sv
design/sample_front.sv
design/correlator_block.sv
design/visibility_drain.sv
design/correlator_top.sv
testbench/tb_correlator.sv

// File: testbench/tb_correlator.sv
`timescale 1ns/1ps
`include "corr_settings.svh"

module tb_correlator;

   localparam int CB         = `CORR_COUNT_BITS;
   localparam int MAX_CYCLES = 4000; // Tests take about 250 cycles with ample margin

   logic                      clk_i    = 1'b0;
   logic                      sw_d;
   logic                      enable_i;
   logic [`CORR_ANTENNAS-1:0] antenna_i;
   logic [CB-1:0]             blocksize_i;
   logic                      credit_i = 1'b0;
   corr_pkg::corr_word_u      word_o;
   logic                      valid_o;
   logic                      overrun_o;

   logic auto_credit   = 1'b1; // Return one credit per word taken
   logic manual_credit = 1'b0;
   logic took          = 1'b0; // Word taken this cycle

   corr_pkg::corr_word_u got_q [$]; // Words seen on the output
   corr_pkg::corr_word_u exp_q [$]; // Words predicted by the model

   // --------------------
   // Shadow model state
   // --------------------
   int unsigned               m_re [`CORR_PAIRS];
   int unsigned               m_im [`CORR_PAIRS];
   logic [`CORR_ANTENNAS-1:0] m_hist; // Previous strobed bits
   int unsigned               m_cnt;
   int unsigned               m_frame;
   int unsigned               m_bs;
   int ant_a [`CORR_PAIRS] = '{0, 0, 0, 1, 1, 2}; // Pairs (0,1)(0,2)(0,3)(1,2)(1,3)(2,3)
   int ant_b [`CORR_PAIRS] = '{1, 2, 3, 2, 3, 3};

   int seed   = 32'hbc31aa44;
   int cycles = 0;
   int errors = 0;
   int checks = 0;

   correlator_top dut0 (
      .clk_i       (clk_i),
      .sw_d        (sw_d),
      .enable_i    (enable_i),
      .antenna_i   (antenna_i),
      .blocksize_i (blocksize_i),
      .credit_i    (credit_i),
      .word_o      (word_o),
      .valid_o     (valid_o),
      .overrun_o   (overrun_o)
   );

   initial begin
      forever #5 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, the expected output words never arrived", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   // Output words taken at the falling edge
   always @(negedge clk_i) begin
      took = (valid_o === 1'b1);
      if (took) begin
         got_q.push_back(word_o);
      end
   end

   always @(posedge clk_i) begin
      credit_i <= auto_credit ? took : manual_credit;
   end

   task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                        input string what);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED at %0t: %s, got %0h, expected %0h", $time, what, actual,
                  expected);
      end
   endtask

   // --------------------
   // Model and drivers
   // --------------------
   task automatic model_add(input logic [`CORR_ANTENNAS-1:0] re);
      corr_pkg::corr_word_u w;
      for (int p = 0; p < `CORR_PAIRS; p++) begin
         if (re[ant_a[p]] == re[ant_b[p]])
            m_re[p]++;
         if (re[ant_a[p]] == m_hist[ant_b[p]])
            m_im[p]++; // Real against delayed quadrature
      end
      m_hist = re;
      m_cnt++;
      if (m_cnt == m_bs + 1) begin // Block full and sent at the next swap
         w             = '0;
         w.hdr.frame   = CB'(m_frame);
         w.hdr.samples = CB'(m_bs + 1);
         exp_q.push_back(w);
         for (int p = 0; p < `CORR_PAIRS; p++) begin
            w              = '0;
            w.vis.kind     = 1'b1;
            w.vis.pair     = corr_pkg::pair_idx_t'(p);
            w.vis.re_count = CB'(m_re[p]);
            w.vis.im_count = CB'(m_im[p]);
            exp_q.push_back(w);
            m_re[p] = 0;
            m_im[p] = 0;
         end
         m_cnt = 0;
         m_frame++;
      end
   endtask

   function automatic logic [`CORR_ANTENNAS-1:0] rand_ant();
      return `CORR_ANTENNAS'($random(seed));
   endfunction

   task automatic apply_reset(input int unsigned bs, input logic auto_mode);
      @(posedge clk_i);
      sw_d          <= 1'b1;
      enable_i      <= 1'b0;
      blocksize_i   <= CB'(bs);
      auto_credit   <= auto_mode;
      manual_credit <= 1'b0;
      repeat (5) @(posedge clk_i);
      sw_d <= 1'b0;
      got_q.delete();
      exp_q.delete();
      m_bs    = bs;
      m_hist  = '0; // History cleared by reset
      m_cnt   = 0;
      m_frame = 0;
      for (int p = 0; p < `CORR_PAIRS; p++) begin
         m_re[p] = 0;
         m_im[p] = 0;
      end
   endtask

   task automatic drive(input logic en, input logic [`CORR_ANTENNAS-1:0] ant);
      @(posedge clk_i);
      enable_i  <= en;
      antenna_i <= ant;
      if (en)
         model_add(ant);
   endtask

   task automatic wait_words(input int n);
      while (got_q.size() < n)
         @(posedge clk_i);
      repeat (4) @(posedge clk_i); // Catch any extra word
   endtask

   task automatic pulse_credit();
      @(posedge clk_i);
      manual_credit <= 1'b1;
      @(posedge clk_i);
      manual_credit <= 1'b0;
      repeat (3) @(posedge clk_i);
   endtask

   task automatic compare_words(input string name);
      check(64'(got_q.size()), 64'(exp_q.size()), {name, " word count"});
      for (int i = 0; i < got_q.size() && i < exp_q.size(); i++)
         check(64'(got_q[i]), 64'(exp_q[i]), $sformatf("%s word %0d", name, i));
   endtask

   // --------------------
   // Tests
   // --------------------
   task automatic identical_antennas();
      apply_reset(7, 1'b1);
      for (int i = 0; i < 17; i++)
         drive(1'b1, 4'hf); // Ninth and seventeenth samples trigger swaps
      drive(1'b0, 4'hf);
      wait_words(14);
      compare_words("identical");
      for (int p = 0; p < `CORR_PAIRS; p++) begin
         check(64'(got_q[1 + p].vis.re_count), 64'd8, "identical re count");
         check(64'(got_q[1 + p].vis.im_count), 64'd7, "identical im count, zero history");
         check(64'(got_q[8 + p].vis.re_count), 64'd8, "identical re count, second frame");
         check(64'(got_q[8 + p].vis.im_count), 64'd8, "identical im count, second frame");
      end
   endtask

   task automatic random_frames();
      apply_reset(15, 1'b1);
      for (int i = 0; i < 33; i++)
         drive(1'b1, rand_ant());
      drive(1'b0, 4'h0);
      wait_words(14);
      compare_words("random");
      check(64'(got_q[0].hdr.samples), 64'd16, "header sample count");
      check(64'(got_q[7].hdr.frame), 64'd1, "second frame number");
      check(64'(overrun_o), 64'd0, "no overrun with free credits");
   endtask

   task automatic enable_gating();
      apply_reset(7, 1'b1);
      for (int k = 0; k < 8; k++) begin
         drive(1'b1, rand_ant());
         drive(1'b0, rand_ant()); // Gated and not counted
         drive(1'b0, rand_ant());
      end
      repeat (4) @(posedge clk_i);
      check(64'(got_q.size()), 64'd0, "words before next enabled sample");
      drive(1'b1, rand_ant());
      drive(1'b0, rand_ant());
      wait_words(7);
      compare_words("gating");
   endtask

   task automatic credit_flow();
      apply_reset(3, 1'b0);
      for (int i = 0; i < 5; i++)
         drive(1'b1, rand_ant());
      drive(1'b0, 4'h0);
      wait_words(4);
      repeat (10) @(posedge clk_i);
      check(64'(got_q.size()), 64'd4, "words sent on initial credits");
      for (int k = 0; k < 3; k++) begin
         pulse_credit();
         check(64'(got_q.size()), 64'(5 + k), "words after one credit");
      end
      compare_words("credit");
   endtask

   task automatic overrun_recovery();
      apply_reset(3, 1'b0);
      for (int i = 0; i < 5; i++)
         drive(1'b1, rand_ant());
      drive(1'b0, 4'h0);
      wait_words(4); // Stalled after header and three pairs
      check(64'(overrun_o), 64'd0, "overrun before second swap");
      for (int i = 0; i < 4; i++)
         drive(1'b1, rand_ant());
      drive(1'b0, 4'h0);
      repeat (2) @(posedge clk_i);
      check(64'(overrun_o), 64'd1, "overrun after dropped frame");
      repeat (3) exp_q.delete(4); // Unsent tail of frame 0
      while (got_q.size() < 11)
         pulse_credit();
      repeat (4) @(posedge clk_i);
      compare_words("overrun");
      check(64'(got_q[4].hdr.frame), 64'd1, "newer frame after overrun");
   endtask

   initial begin
      sw_d        = 1'b1;
      enable_i    = 1'b0;
      antenna_i   = '0;
      blocksize_i = '0;
      identical_antennas();
      random_frames();
      enable_gating();
      credit_flow();
      overrun_recovery();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule
